//--- all.f
logic/dcache_pkg.sv
logic/dcache_tag_array.sv
logic/dcache_data_array.sv
logic/dcache_datapath.sv
logic/dcache_control.sv
logic/dcache_top.sv
sim/dcache_mem_model.sv
sim/dcache_tb.sv

//--- logic/dcache_control.sv
`timescale 1ns/100ps

module dcache_control (
  input logic clk,
  input logic rst,
  input logic cpu_read,
  input logic cpu_write,
  input logic hit,
  input logic victim_dirty,
  input logic pmem_resp,
  output logic cpu_resp,
  output logic pmem_read,
  output logic pmem_write,
  output logic addr_sel,
  output dcache_pkg::array_ctrl_t array_ctrl,
  output logic [31:0] miss_count
);

  dcache_pkg::ctrl_state_e state;
  dcache_pkg::ctrl_state_e next_state;
  logic cpu_req_valid;

  assign cpu_req_valid = cpu_read | cpu_write;

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= dcache_pkg::idle;
    else
      state <= next_state;
  end

  // one count per evict, so every fill maps to one miss
  always_ff @(posedge clk)
  begin
    if (rst)
      miss_count <= '0;
    else if (state == dcache_pkg::evict)
      miss_count <= miss_count + 32'd1;
  end

  function void set_defaults();
    cpu_resp = 1'b0;
    pmem_read = 1'b0;
    pmem_write = 1'b0;
    addr_sel = 1'b0;
    array_ctrl = '0;
  endfunction

  always_comb
  begin
    next_state = state;
    set_defaults();
    case (state)
      dcache_pkg::idle:
      begin
        if (cpu_req_valid)
          next_state = dcache_pkg::check;
      end
      dcache_pkg::check:
      begin
        if (!cpu_req_valid)
          next_state = dcache_pkg::idle;
        else if (!hit)
          next_state = dcache_pkg::evict;
        else
        begin
          // hit path, respond this cycle
          cpu_resp = 1'b1;
          array_ctrl.load_lru = 1'b1;
          if (cpu_write)
          begin
            array_ctrl.hit_write = 1'b1;
            array_ctrl.set_dirty = 1'b1;
          end
        end
      end
      dcache_pkg::evict:
      begin
        array_ctrl.latch_victim = 1'b1;
        if (victim_dirty)
          next_state = dcache_pkg::write_back;
        else
          next_state = dcache_pkg::fill;
      end
      dcache_pkg::write_back:
      begin
        pmem_write = 1'b1;
        addr_sel = 1'b1;
        array_ctrl.use_victim = 1'b1;
        if (pmem_resp)
        begin
          array_ctrl.clear_dirty = 1'b1;
          next_state = dcache_pkg::fill;
        end
      end
      dcache_pkg::fill:
      begin
        pmem_read = 1'b1;
        array_ctrl.use_victim = 1'b1;
        if (pmem_resp)
        begin
          // line, tag and valid land on this edge
          array_ctrl.load_line = 1'b1;
          array_ctrl.clear_dirty = 1'b1;
          next_state = dcache_pkg::check;
        end
      end
      default:
        next_state = dcache_pkg::idle;
    endcase
  end

endmodule : dcache_control

//--- logic/dcache_data_array.sv
`timescale 1ns/100ps

module dcache_data_array #(
  parameter int num_sets = 8,
  localparam int index_bits = $clog2(num_sets)
) (
  input logic clk,
  input logic [index_bits-1:0] index,
  input logic wr_way,
  input logic load_line,
  input logic [dcache_pkg::line_bits-1:0] line_in,
  output logic [dcache_pkg::line_bits-1:0] line0,
  output logic [dcache_pkg::line_bits-1:0] line1
);

  logic [dcache_pkg::line_bits-1:0] lines [2][num_sets];

  // merged hit line or fill line, one way at a time
  always_ff @(posedge clk)
  begin
    if (load_line)
      lines[wr_way][index] <= line_in;
  end

  assign line0 = lines[0][index];
  assign line1 = lines[1][index];

endmodule : dcache_data_array

//--- logic/dcache_datapath.sv
`timescale 1ns/100ps

module dcache_datapath #(
  parameter int num_sets = 8
) (
  input logic clk,
  input logic rst,
  input dcache_pkg::cpu_req_t cpu_req,
  input dcache_pkg::array_ctrl_t array_ctrl,
  input logic addr_sel,
  input logic [dcache_pkg::line_bits-1:0] pmem_rdata,
  output logic hit,
  output logic victim_dirty,
  output logic [dcache_pkg::word_bits-1:0] cpu_rdata,
  output logic [dcache_pkg::addr_bits-1:0] pmem_addr,
  output logic [dcache_pkg::line_bits-1:0] pmem_wdata
);

  localparam int index_bits = $clog2(num_sets);
  localparam int tag_bits = dcache_pkg::addr_bits - index_bits - dcache_pkg::offset_bits;
  localparam int word_sel_bits = $clog2(dcache_pkg::words_per_line);
  localparam int byte_bits = dcache_pkg::offset_bits - word_sel_bits;
  localparam int bytes_per_word = dcache_pkg::word_bits / 8;

  logic [index_bits-1:0] index;
  logic [tag_bits-1:0] req_tag;
  logic [word_sel_bits-1:0] word_off;
  logic [1:0][tag_bits-1:0] tags;
  logic [1:0] valid;
  logic [1:0] dirty;
  logic lru;
  logic [1:0] way_hit;
  logic hit_way;
  logic victim_q;
  logic wr_way;
  logic [dcache_pkg::line_bits-1:0] line0;
  logic [dcache_pkg::line_bits-1:0] line1;
  logic [dcache_pkg::line_bits-1:0] line_in;
  logic [dcache_pkg::words_per_line-1:0][dcache_pkg::word_bits-1:0] hit_words;
  logic [dcache_pkg::words_per_line-1:0][dcache_pkg::word_bits-1:0] merged_words;

  assign index = cpu_req.addr[dcache_pkg::offset_bits +: index_bits];
  assign req_tag = cpu_req.addr[dcache_pkg::addr_bits-1 -: tag_bits];
  assign word_off = cpu_req.addr[byte_bits +: word_sel_bits];

  assign way_hit[0] = valid[0] && (tags[0] == req_tag);
  assign way_hit[1] = valid[1] && (tags[1] == req_tag);
  assign hit = |way_hit;
  assign hit_way = way_hit[1];

  // victim is the lru way, held from evict until the fill lands
  always_ff @(posedge clk)
  begin
    if (rst)
      victim_q <= 1'b0;
    else if (array_ctrl.latch_victim)
      victim_q <= lru;
  end

  // only looked at in evict, where the lru way becomes the victim
  assign victim_dirty = valid[lru] & dirty[lru];
  assign wr_way = array_ctrl.use_victim ? victim_q : hit_way;

  assign hit_words = hit_way ? line1 : line0;
  assign cpu_rdata = hit_words[word_off];

  always_comb
  begin
    merged_words = hit_words;
    for (int b = 0; b < bytes_per_word; b++)
    begin
      if (cpu_req.byte_en[b])
        merged_words[word_off][b*8 +: 8] = cpu_req.wdata[b*8 +: 8];
    end
  end

  assign line_in = array_ctrl.load_line ? pmem_rdata : merged_words;

  // write-back uses the stored tag, fill the request tag
  assign pmem_addr = {addr_sel ? tags[victim_q] : req_tag, index,
                      {dcache_pkg::offset_bits{1'b0}}};
  assign pmem_wdata = victim_q ? line1 : line0;

  dcache_tag_array #(
    .num_sets(num_sets)
  ) tag_array_i (
    .clk(clk),
    .rst(rst),
    .index(index),
    .wr_way(wr_way),
    .load_tag(array_ctrl.load_line),
    .set_dirty(array_ctrl.set_dirty),
    .clear_dirty(array_ctrl.clear_dirty),
    .load_lru(array_ctrl.load_lru),
    .lru_value(~hit_way),
    .tag_in(req_tag),
    .tags(tags),
    .valid(valid),
    .dirty(dirty),
    .lru(lru)
  );

  dcache_data_array #(
    .num_sets(num_sets)
  ) data_array_i (
    .clk(clk),
    .index(index),
    .wr_way(wr_way),
    .load_line(array_ctrl.hit_write | array_ctrl.load_line),
    .line_in(line_in),
    .line0(line0),
    .line1(line1)
  );

endmodule : dcache_datapath

//--- logic/dcache_pkg.sv
package dcache_pkg;

  localparam int word_bits = 32;
  localparam int words_per_line = 4;
  localparam int line_bits = 128;
  // byte offset within a line
  localparam int offset_bits = 4;
  localparam int addr_bits = 32;

  typedef struct packed {
    logic read;
    logic write;
    logic [addr_bits-1:0] addr;
    logic [word_bits-1:0] wdata;
    logic [word_bits/8-1:0] byte_en;
  } cpu_req_t;

  // addr is always line aligned
  typedef struct packed {
    logic read;
    logic write;
    logic [addr_bits-1:0] addr;
    logic [line_bits-1:0] wdata;
  } pmem_req_t;

  typedef enum logic [2:0] {
    idle,
    check,
    evict,
    write_back,
    fill
  } ctrl_state_e;

  // write strobes from control into the arrays
  typedef struct packed {
    logic hit_write;
    logic set_dirty;
    logic load_line;
    logic clear_dirty;
    logic load_lru;
    // capture the lru way as victim
    logic latch_victim;
    // array writes target the victim way, not the hit way
    logic use_victim;
  } array_ctrl_t;

endpackage : dcache_pkg

//--- logic/dcache_tag_array.sv
`timescale 1ns/100ps

module dcache_tag_array #(
  parameter int num_sets = 8,
  localparam int index_bits = $clog2(num_sets),
  localparam int tag_bits = dcache_pkg::addr_bits - index_bits - dcache_pkg::offset_bits
) (
  input logic clk,
  input logic rst,
  input logic [index_bits-1:0] index,
  input logic wr_way,
  input logic load_tag,
  input logic set_dirty,
  input logic clear_dirty,
  input logic load_lru,
  input logic lru_value,
  input logic [tag_bits-1:0] tag_in,
  output logic [1:0][tag_bits-1:0] tags,
  output logic [1:0] valid,
  output logic [1:0] dirty,
  output logic lru
);

  logic [1:0][tag_bits-1:0] tag_q [num_sets];
  logic [num_sets-1:0][1:0] valid_q;
  logic [num_sets-1:0][1:0] dirty_q;
  // lru bit names the way to evict next
  logic [num_sets-1:0] lru_q;

  always_ff @(posedge clk)
  begin
    if (load_tag)
      tag_q[index][wr_way] <= tag_in;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
      dirty_q <= '0;
      lru_q <= '0;
    end
    else
    begin
      if (load_tag)
        valid_q[index][wr_way] <= 1'b1;
      if (set_dirty)
        dirty_q[index][wr_way] <= 1'b1;
      else if (clear_dirty)
        dirty_q[index][wr_way] <= 1'b0;
      if (load_lru)
        lru_q[index] <= lru_value;
    end
  end

  // combinational read of the addressed set
  always_comb
  begin
    tags = tag_q[index];
    valid = valid_q[index];
    dirty = dirty_q[index];
    lru = lru_q[index];
  end

endmodule : dcache_tag_array

//--- logic/dcache_top.sv
`timescale 1ns/100ps

module dcache_top #(
  parameter int num_sets = 8
) (
  input logic clk,
  input logic rst,
  input dcache_pkg::cpu_req_t cpu_req,
  output logic cpu_resp,
  output logic [dcache_pkg::word_bits-1:0] cpu_rdata,
  output dcache_pkg::pmem_req_t pmem_req,
  input logic pmem_resp,
  input logic [dcache_pkg::line_bits-1:0] pmem_rdata,
  output logic [31:0] miss_count
);

  logic hit;
  logic victim_dirty;
  logic addr_sel;
  logic pmem_read;
  logic pmem_write;
  logic [dcache_pkg::addr_bits-1:0] pmem_addr;
  logic [dcache_pkg::line_bits-1:0] pmem_wdata;
  dcache_pkg::array_ctrl_t array_ctrl;

  assign pmem_req = '{read: pmem_read, write: pmem_write, addr: pmem_addr, wdata: pmem_wdata};

  dcache_control control_i (
    .clk(clk),
    .rst(rst),
    .cpu_read(cpu_req.read),
    .cpu_write(cpu_req.write),
    .hit(hit),
    .victim_dirty(victim_dirty),
    .pmem_resp(pmem_resp),
    .cpu_resp(cpu_resp),
    .pmem_read(pmem_read),
    .pmem_write(pmem_write),
    .addr_sel(addr_sel),
    .array_ctrl(array_ctrl),
    .miss_count(miss_count)
  );

  dcache_datapath #(
    .num_sets(num_sets)
  ) datapath_i (
    .clk(clk),
    .rst(rst),
    .cpu_req(cpu_req),
    .array_ctrl(array_ctrl),
    .addr_sel(addr_sel),
    .pmem_rdata(pmem_rdata),
    .hit(hit),
    .victim_dirty(victim_dirty),
    .cpu_rdata(cpu_rdata),
    .pmem_addr(pmem_addr),
    .pmem_wdata(pmem_wdata)
  );

endmodule : dcache_top

//--- sim/dcache_mem_model.sv
`timescale 1ns/100ps

module dcache_mem_model (
  input logic clk,
  input logic rst,
  input dcache_pkg::pmem_req_t pmem_req,
  output logic pmem_resp,
  output logic [dcache_pkg::line_bits-1:0] pmem_rdata
);

  localparam int resp_delay = 3;

  // sparse shadow memory keyed by line address
  logic [dcache_pkg::line_bits-1:0] mem [logic [31:0]];
  logic [31:0] wr_addr_log [$];
  logic [dcache_pkg::line_bits-1:0] wr_data_log [$];
  logic [31:0] rd_addr_log [$];
  int wait_cnt;

  // lines never preloaded read back as a pattern of their address
  function automatic logic [127:0] read_line(input logic [31:0] addr);
    if (mem.exists(addr))
      return mem[addr];
    return {addr ^ 32'h5a5a_0003, addr ^ 32'h0f0f_0002, ~addr, addr};
  endfunction

  task automatic preload(input logic [31:0] addr, input logic [127:0] line);
    mem[addr] = line;
  endtask

  always @(posedge clk)
  begin
    if (rst)
    begin
      pmem_resp <= 1'b0;
      pmem_rdata <= '0;
      wait_cnt <= 0;
    end
    else if (pmem_resp)
    begin
      // cache drops its request after the response cycle
      pmem_resp <= 1'b0;
      wait_cnt <= 0;
    end
    else if (pmem_req.read || pmem_req.write)
    begin
      if (wait_cnt == resp_delay - 1)
      begin
        pmem_resp <= 1'b1;
        if (pmem_req.write)
        begin
          mem[pmem_req.addr] = pmem_req.wdata;
          wr_addr_log.push_back(pmem_req.addr);
          wr_data_log.push_back(pmem_req.wdata);
        end
        else
        begin
          pmem_rdata <= read_line(pmem_req.addr);
          rd_addr_log.push_back(pmem_req.addr);
        end
      end
      else
        wait_cnt <= wait_cnt + 1;
    end
  end

endmodule : dcache_mem_model

//--- sim/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

  localparam int num_sets = 8;
  localparam int index_bits = $clog2(num_sets);
  localparam int tag_bits = dcache_pkg::addr_bits - index_bits - dcache_pkg::offset_bits;
  localparam int resp_timeout = 50;
  localparam int num_random = 300;

  logic clk;
  logic rst;
  dcache_pkg::cpu_req_t cpu_req;
  logic cpu_resp;
  logic [31:0] cpu_rdata;
  dcache_pkg::pmem_req_t pmem_req;
  logic pmem_resp;
  logic [127:0] pmem_rdata;
  logic [31:0] miss_count;

  logic [31:0] lfsr_state;
  logic [tag_bits-1:0] tag_pool [3];
  logic [index_bits-1:0] set_pool [2];

  // reference two-way cache and byte image of every line
  logic [tag_bits-1:0] ref_tag [num_sets][2];
  logic [1:0] ref_valid [num_sets];
  logic [1:0] ref_dirty [num_sets];
  logic ref_lru [num_sets];
  logic [127:0] line_img [logic [31:0]];
  int exp_misses;

  dcache_top #(
    .num_sets(num_sets)
  ) dcache_top_i (
    .clk(clk),
    .rst(rst),
    .cpu_req(cpu_req),
    .cpu_resp(cpu_resp),
    .cpu_rdata(cpu_rdata),
    .pmem_req(pmem_req),
    .pmem_resp(pmem_resp),
    .pmem_rdata(pmem_rdata),
    .miss_count(miss_count)
  );

  dcache_mem_model mem_i (
    .clk(clk),
    .rst(rst),
    .pmem_req(pmem_req),
    .pmem_resp(pmem_resp),
    .pmem_rdata(pmem_rdata)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [127:0] exp,
                                 input logic [127:0] got);
    $display("Mismatch %s: expected 0x%0h, got 0x%0h", name, exp, got);
    stop_with_failure();
  endtask

  // galois lfsr, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out;
  endfunction

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  function automatic logic [31:0] addr_of(input int t, input int s, input int w);
    return {tag_pool[t], set_pool[s], w[1:0], 2'b00};
  endfunction

  task automatic access(input logic is_write, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] be);
    logic [index_bits-1:0] set;
    logic [tag_bits-1:0] tag;
    logic [31:0] line_addr;
    logic [31:0] victim_addr;
    logic [31:0] exp_word;
    logic [1:0] word;
    int way;
    int rd_before;
    int wr_before;
    int exp_rd;
    int exp_wr;
    int cycles;

    set = addr[dcache_pkg::offset_bits +: index_bits];
    tag = addr[31 -: tag_bits];
    line_addr = {addr[31:dcache_pkg::offset_bits], 4'h0};
    word = addr[3:2];
    way = -1;
    for (int w = 0; w < 2; w++)
      if (ref_valid[set][w] && ref_tag[set][w] == tag)
        way = w;
    rd_before = mem_i.rd_addr_log.size();
    wr_before = mem_i.wr_addr_log.size();
    cpu_req = '{read: !is_write, write: is_write, addr: addr, wdata: wdata, byte_en: be};
    cycles = 0;
    @(negedge clk);
    while (cpu_resp !== 1'b1)
    begin
      cycles++;
      if (cycles > resp_timeout)
      begin
        $display("timed out waiting for cpu_resp, address 0x%h", addr);
        stop_with_failure();
      end
      @(negedge clk);
    end
    exp_rd = rd_before;
    exp_wr = wr_before;
    if (way < 0)
    begin
      // miss replaces the lru way
      exp_misses++;
      way = ref_lru[set];
      exp_rd++;
      if (ref_valid[set][way] && ref_dirty[set][way])
        exp_wr++;
    end
    assert (mem_i.rd_addr_log.size() == exp_rd)
    else report_mismatch("pmem read count", exp_rd, mem_i.rd_addr_log.size());
    assert (mem_i.wr_addr_log.size() == exp_wr)
    else report_mismatch("pmem write count", exp_wr, mem_i.wr_addr_log.size());
    if (exp_wr > wr_before)
    begin
      victim_addr = {ref_tag[set][way], set, 4'h0};
      assert (mem_i.wr_addr_log[wr_before] == victim_addr)
      else report_mismatch("pmem_req.addr", victim_addr, mem_i.wr_addr_log[wr_before]);
      assert (mem_i.wr_data_log[wr_before] == line_img[victim_addr])
      else report_mismatch("pmem_req.wdata", line_img[victim_addr], mem_i.wr_data_log[wr_before]);
    end
    if (exp_rd > rd_before)
    begin
      assert (mem_i.rd_addr_log[rd_before] == line_addr)
      else report_mismatch("pmem_req.addr", line_addr, mem_i.rd_addr_log[rd_before]);
      ref_tag[set][way] = tag;
      ref_valid[set][way] = 1'b1;
      ref_dirty[set][way] = 1'b0;
    end
    ref_lru[set] = (way == 0);
    if (is_write)
    begin
      for (int b = 0; b < 4; b++)
        if (be[b])
          line_img[line_addr][word*32 + b*8 +: 8] = wdata[b*8 +: 8];
      ref_dirty[set][way] = 1'b1;
    end
    else
    begin
      exp_word = line_img[line_addr][word*32 +: 32];
      assert (cpu_rdata == exp_word)
      else report_mismatch("cpu_rdata", exp_word, cpu_rdata);
    end
    @(posedge clk);
    #2;
    cpu_req = '0;
  endtask

  initial
  begin
    logic [31:0] la;
    logic [127:0] line;
    int t;
    int s;
    int w;

    rst = 1'b1;
    cpu_req = '0;
    lfsr_state = 32'h72db;
    exp_misses = 0;
    tag_pool[0] = 25'h000_0012;
    tag_pool[1] = 25'h001_5a3c;
    tag_pool[2] = 25'h000_7e01;
    set_pool[0] = 3'd1;
    set_pool[1] = 3'd6;
    for (int i = 0; i < num_sets; i++)
    begin
      ref_valid[i] = 2'b00;
      ref_dirty[i] = 2'b00;
      ref_lru[i] = 1'b0;
    end
    for (int i = 0; i < 6; i++)
    begin
      la = {tag_pool[i % 3], set_pool[i / 3], 4'h0};
      line = {lfsr_bits(32), lfsr_bits(32), lfsr_bits(32), lfsr_bits(32)};
      line_img[la] = line;
      mem_i.preload(la, line);
    end

    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    @(negedge clk);
    assert (cpu_resp == 1'b0) else report_mismatch("cpu_resp", 0, cpu_resp);
    assert (pmem_req.read == 1'b0) else report_mismatch("pmem_req.read", 0, pmem_req.read);
    assert (pmem_req.write == 1'b0) else report_mismatch("pmem_req.write", 0, pmem_req.write);
    assert (miss_count == 0) else report_mismatch("miss_count", 0, miss_count);
    @(posedge clk);
    #2;

    // three tags through one set, the lru way decides which later access misses
    access(1'b1, addr_of(0, 0, 1), 32'hcafe_f00d, 4'b0110);
    access(1'b0, addr_of(1, 0, 0), 32'h0, 4'h0);
    access(1'b0, addr_of(0, 0, 1), 32'h0, 4'h0);
    access(1'b0, addr_of(2, 0, 3), 32'h0, 4'h0);
    access(1'b0, addr_of(1, 0, 2), 32'h0, 4'h0);
    access(1'b0, addr_of(0, 0, 1), 32'h0, 4'h0);

    for (int i = 0; i < num_random; i++)
    begin
      t = lfsr_bits(2) % 3;
      s = lfsr_bits(1);
      w = lfsr_bits(2);
      access(lfsr_bits(1), addr_of(t, s, w), lfsr_bits(32), lfsr_bits(4));
      // sometimes let the controller fall back to idle
      if (lfsr_bits(2) == 0)
      begin
        @(posedge clk);
        #2;
      end
    end

    @(negedge clk);
    assert (miss_count == exp_misses)
    else report_mismatch("miss_count", exp_misses, miss_count);
    $display("Result: PASSED");
    $finish;
  end

endmodule : dcache_tb
